/* logic/jesd_tx_consts.svh */
`ifndef JESD_TX_CONSTS_SVH
`define JESD_TX_CONSTS_SVH

// Link geometry
`define JESD_NUM_LANES       2
`define JESD_OCTETS_PER_BEAT 4
`define JESD_ILAS_MFRAMES    4

// 8b/10b control characters, data byte of the K code
`define JESD_K_R 8'h1C
`define JESD_K_A 8'h7C
`define JESD_K_Q 8'h9C
`define JESD_K_K 8'hBC
`define JESD_K_F 8'hFC

// Register block constants
`define JESD_REG_ID_VALUE         16'h204B
`define JESD_RST_OCTETS_PER_FRAME 3'd2
`define JESD_RST_FRAMES_PER_MF    6'd16

`endif

/* logic/jesd_cfg_pkg.sv */
package jesd_cfg_pkg;

  // Word addresses of the configuration registers
  typedef enum logic [2:0] {
    REG_ID     = 3'd0,
    REG_CTRL   = 3'd1,
    REG_FRAME  = 3'd2,
    REG_MFRAME = 3'd3,
    REG_STATUS = 3'd4
  } reg_addr_t;

  typedef logic [31:0] wb_word_t;

  // Frames per multiframe, K
  typedef logic [5:0] mf_len_t;

  typedef struct packed {
    logic char_replace;
    logic link_enable;
  } ctrl_reg_t;

endpackage

/* logic/jesd_link_pkg.sv */
package jesd_link_pkg;

  typedef enum logic [1:0] {
    PHASE_CGS  = 2'd0,
    PHASE_ILAS = 2'd1,
    PHASE_DATA = 2'd2
  } link_phase_t;

  // Beat count within a multiframe
  typedef logic [7:0] beat_t;

  // One flag per octet of a beat
  typedef logic [3:0] frame_mark_t;

  typedef logic [1:0] ilas_mframe_t;
  typedef logic [7:0] octet_t;

endpackage

/* logic/jesd_tx_regs.sv */
`timescale 1ns/1ps

`include "jesd_tx_consts.svh"

module jesd_tx_regs (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       i_wb_cyc,
  input  logic                       i_wb_stb,
  input  logic                       i_wb_we,
  input  logic [2:0]                 i_wb_adr,
  input  jesd_cfg_pkg::wb_word_t     i_wb_dat,
  output jesd_cfg_pkg::wb_word_t     o_wb_dat,
  output logic                       o_wb_ack,
  input  jesd_link_pkg::link_phase_t i_link_phase,
  input  logic                       i_sync_n,
  output logic                       o_link_enable,
  output logic                       o_char_replace,
  output logic [2:0]                 o_octets_per_frame,
  output jesd_link_pkg::beat_t       o_beats_per_mf
);
  import jesd_cfg_pkg::*;
  import jesd_link_pkg::*;

  ctrl_reg_t  ctrl_q;
  logic [2:0] frame_len_q;
  mf_len_t    mf_len_q;
  reg_addr_t  addr;
  logic       req_new;
  wb_word_t   rd_word;
  logic [8:0] octets_per_mf;

  // A request is served once, on the first cycle it is seen
  assign req_new = i_wb_cyc && i_wb_stb && !o_wb_ack;
  assign addr    = reg_addr_t'(i_wb_adr);

  always_ff @(posedge clk) begin
    if (reset) begin
      o_wb_ack <= 1'b0;
    end else begin
      o_wb_ack <= req_new;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ctrl_q      <= '{char_replace: 1'b1, link_enable: 1'b0};
      frame_len_q <= `JESD_RST_OCTETS_PER_FRAME;
      mf_len_q    <= `JESD_RST_FRAMES_PER_MF;
    end else if (req_new && i_wb_we) begin
      case (addr)
        REG_CTRL:   ctrl_q <= ctrl_reg_t'(i_wb_dat[1:0]);
        REG_FRAME:  frame_len_q <= i_wb_dat[2:0];
        REG_MFRAME: mf_len_q <= i_wb_dat[5:0];
        default: ;
      endcase
    end
  end

  always_comb begin
    case (addr)
      REG_ID:     rd_word = {16'd0, `JESD_REG_ID_VALUE};
      REG_CTRL:   rd_word = {30'd0, ctrl_q};
      REG_FRAME:  rd_word = {29'd0, frame_len_q};
      REG_MFRAME: rd_word = {26'd0, mf_len_q};
      REG_STATUS: rd_word = {29'd0, i_sync_n, i_link_phase};
      default:    rd_word = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (req_new) begin
      o_wb_dat <= rd_word;
    end
  end

  // Beats per multiframe is F*K/4
  assign octets_per_mf = 9'(frame_len_q) * 9'(mf_len_q);

  assign o_link_enable      = ctrl_q.link_enable;
  assign o_char_replace     = ctrl_q.char_replace;
  assign o_octets_per_frame = frame_len_q;
  assign o_beats_per_mf     = beat_t'(octets_per_mf >> 2);

endmodule

/* logic/jesd_tx_lmfc.sv */
`timescale 1ns/1ps

`include "jesd_tx_consts.svh"

module jesd_tx_lmfc (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       i_sysref,
  input  logic [2:0]                 i_octets_per_frame,
  input  jesd_link_pkg::beat_t       i_beats_per_mf,
  output logic                       o_lmfc_edge,
  output jesd_link_pkg::beat_t       o_beat,
  output jesd_link_pkg::frame_mark_t o_eof,
  output jesd_link_pkg::frame_mark_t o_eomf
);
  import jesd_link_pkg::*;

  logic  sysref_q;
  logic  sysref_qq;
  logic  sysref_rise;
  beat_t last_beat;

  // ************************************************************
  // SYSREF edge detect and beat counter
  // ************************************************************

  always_ff @(posedge clk) begin
    if (reset) begin
      sysref_q  <= 1'b0;
      sysref_qq <= 1'b0;
    end else begin
      sysref_q  <= i_sysref;
      sysref_qq <= sysref_q;
    end
  end

  assign sysref_rise = sysref_q && !sysref_qq;
  assign last_beat   = i_beats_per_mf - 8'd1;

  // Every SYSREF edge realigns, so the next beat is 0
  always_ff @(posedge clk) begin
    if (reset) begin
      o_beat <= '0;
    end else if (sysref_rise || o_beat >= last_beat) begin
      o_beat <= '0;
    end else begin
      o_beat <= o_beat + 8'd1;
    end
  end

  assign o_lmfc_edge = (o_beat == '0);

  // ************************************************************
  // Frame marks
  // ************************************************************

  always_comb begin
    case (i_octets_per_frame)
      3'd1:    o_eof = 4'b1111;
      3'd2:    o_eof = 4'b1010;
      default: o_eof = 4'b1000;
    endcase
  end

  // Only the last octet of the last beat closes the multiframe
  assign o_eomf = (o_beat == last_beat) ?
                  frame_mark_t'(1) << (`JESD_OCTETS_PER_BEAT - 1) : '0;

endmodule

/* logic/jesd_tx_ctrl.sv */
`timescale 1ns/1ps

`include "jesd_tx_consts.svh"

module jesd_tx_ctrl (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        i_link_enable,
  input  logic                        i_sync_n,
  input  logic                        i_lmfc_edge,
  output jesd_link_pkg::link_phase_t  o_phase,
  output jesd_link_pkg::ilas_mframe_t o_ilas_mframe,
  output logic                        o_tx_ready
);
  import jesd_link_pkg::*;

  link_phase_t  phase_q;
  ilas_mframe_t mf_cnt;
  logic         link_up;

  assign link_up = i_link_enable && i_sync_n;

  // ************************************************************
  // CGS / ILAS / DATA
  // ************************************************************

  always_ff @(posedge clk) begin
    if (reset) begin
      phase_q <= PHASE_CGS;
      mf_cnt  <= '0;
    end else if (!link_up) begin
      // Sync request or disable drops back to CGS at once
      phase_q <= PHASE_CGS;
      mf_cnt  <= '0;
    end else begin
      case (phase_q)
        PHASE_CGS: begin
          if (i_lmfc_edge) begin
            phase_q <= PHASE_ILAS;
            mf_cnt  <= '0;
          end
        end
        PHASE_ILAS: begin
          if (i_lmfc_edge) begin
            if (mf_cnt == ilas_mframe_t'(`JESD_ILAS_MFRAMES - 1)) begin
              phase_q <= PHASE_DATA;
            end else begin
              mf_cnt <= mf_cnt + 2'd1;
            end
          end
        end
        PHASE_DATA: ;
        default: phase_q <= PHASE_CGS;
      endcase
    end
  end

  // Multiframe index of the current beat, the edge of this beat included
  assign o_ilas_mframe = mf_cnt + ilas_mframe_t'(i_lmfc_edge);

  assign o_phase    = phase_q;
  assign o_tx_ready = (phase_q == PHASE_DATA);

endmodule

/* logic/jesd_tx_lane.sv */
`timescale 1ns/1ps

`include "jesd_tx_consts.svh"

module jesd_tx_lane #(
  parameter int LANE_ID = 0
) (
  input  logic                                 clk,
  input  logic                                 reset,
  input  jesd_link_pkg::link_phase_t           i_phase,
  input  jesd_link_pkg::ilas_mframe_t          i_ilas_mframe,
  input  jesd_link_pkg::beat_t                 i_beat,
  input  jesd_link_pkg::frame_mark_t           i_eof,
  input  jesd_link_pkg::frame_mark_t           i_eomf,
  input  logic [2:0]                           i_octets_per_frame,
  input  jesd_link_pkg::beat_t                 i_beats_per_mf,
  input  logic                                 i_char_replace,
  input  logic [8*`JESD_OCTETS_PER_BEAT-1:0]   i_tx_data,
  input  logic                                 i_tx_valid,
  output logic [8*`JESD_OCTETS_PER_BEAT-1:0]   o_phy_data,
  output jesd_link_pkg::frame_mark_t           o_phy_charisk
);
  import jesd_link_pkg::*;

  localparam int NOCT = `JESD_OCTETS_PER_BEAT;

  logic [9:0]          octets_per_mf;
  logic [9:0]          frames_per_mf;
  logic [9:0]          mf_last_octet;
  logic [9:0]          oct_idx;
  octet_t              f_minus_1;
  octet_t              k_minus_1;
  octet_t              tx_oct;
  octet_t              chain_oct;
  octet_t              last_eof_oct;
  logic [8*NOCT-1:0]   next_data;
  frame_mark_t         next_k;

  // ************************************************************
  // ILAS configuration fields
  // ************************************************************

  assign octets_per_mf = 10'(i_beats_per_mf) * 10'(NOCT);
  assign mf_last_octet = octets_per_mf - 10'd1;

  always_comb begin
    case (i_octets_per_frame)
      3'd1:    frames_per_mf = octets_per_mf;
      3'd2:    frames_per_mf = octets_per_mf >> 1;
      default: frames_per_mf = octets_per_mf >> 2;
    endcase
  end

  assign f_minus_1 = octet_t'(i_octets_per_frame) - 8'd1;
  assign k_minus_1 = octet_t'(frames_per_mf - 10'd1);

  // ************************************************************
  // Octet builder
  // ************************************************************

  always_comb begin
    chain_oct = last_eof_oct;
    next_data = '0;
    next_k    = '0;
    oct_idx   = '0;
    tx_oct    = '0;
    for (int p = 0; p < NOCT; p++) begin
      oct_idx = 10'(i_beat) * 10'(NOCT) + 10'(p);
      tx_oct  = i_tx_valid ? i_tx_data[8*p +: 8] : 8'h00;
      case (i_phase)
        PHASE_ILAS: begin
          next_data[8*p +: 8] = oct_idx[7:0];
          if (oct_idx == 10'd0) begin
            next_data[8*p +: 8] = `JESD_K_R;
            next_k[p] = 1'b1;
          end else if (oct_idx == mf_last_octet) begin
            next_data[8*p +: 8] = `JESD_K_A;
            next_k[p] = 1'b1;
          end else if (i_ilas_mframe == 2'd1) begin
            // Second multiframe carries the link parameters
            case (oct_idx)
              10'd1: begin
                next_data[8*p +: 8] = `JESD_K_Q;
                next_k[p] = 1'b1;
              end
              10'd2:   next_data[8*p +: 8] = octet_t'(LANE_ID);
              10'd3:   next_data[8*p +: 8] = f_minus_1;
              10'd4:   next_data[8*p +: 8] = k_minus_1;
              default: ;
            endcase
          end
        end
        PHASE_DATA: begin
          next_data[8*p +: 8] = tx_oct;
          if (i_char_replace && i_eof[p] && tx_oct == chain_oct) begin
            next_data[8*p +: 8] = i_eomf[p] ? `JESD_K_A : `JESD_K_F;
            next_k[p] = 1'b1;
          end
          // Compare against the original octet, never the replacement
          if (i_eof[p]) begin
            chain_oct = tx_oct;
          end
        end
        default: begin
          next_data[8*p +: 8] = `JESD_K_K;
          next_k[p] = 1'b1;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset || i_phase != PHASE_DATA) begin
      last_eof_oct <= '0;
    end else begin
      last_eof_oct <= chain_oct;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      o_phy_data    <= {NOCT{`JESD_K_K}};
      o_phy_charisk <= '1;
    end else begin
      o_phy_data    <= next_data;
      o_phy_charisk <= next_k;
    end
  end

endmodule

/* logic/jesd_tx.sv */
`timescale 1ns/1ps

`include "jesd_tx_consts.svh"

module jesd_tx (
  input  logic                                                clk,
  input  logic                                                reset,
  input  logic                                                i_wb_cyc,
  input  logic                                                i_wb_stb,
  input  logic                                                i_wb_we,
  input  logic [2:0]                                          i_wb_adr,
  input  jesd_cfg_pkg::wb_word_t                              i_wb_dat,
  output jesd_cfg_pkg::wb_word_t                              o_wb_dat,
  output logic                                                o_wb_ack,
  input  logic                                                i_sysref,
  input  logic                                                i_sync_n,
  input  logic [`JESD_NUM_LANES*`JESD_OCTETS_PER_BEAT*8-1:0]  i_tx_data,
  input  logic                                                i_tx_valid,
  output logic                                                o_tx_ready,
  output logic [`JESD_NUM_LANES*`JESD_OCTETS_PER_BEAT*8-1:0]  o_phy_data,
  output logic [`JESD_NUM_LANES*`JESD_OCTETS_PER_BEAT-1:0]    o_phy_charisk,
  output logic                                                o_lmfc_edge
);
  import jesd_link_pkg::*;

  localparam int NOCT      = `JESD_OCTETS_PER_BEAT;
  localparam int LANE_BITS = 8 * NOCT;

  logic         link_enable;
  logic         char_replace;
  logic [2:0]   octets_per_frame;
  beat_t        beats_per_mf;
  beat_t        beat;
  frame_mark_t  eof;
  frame_mark_t  eomf;
  link_phase_t  link_phase;
  ilas_mframe_t ilas_mframe;

  jesd_tx_regs regs_i (
    .clk                (clk),
    .reset              (reset),
    .i_wb_cyc           (i_wb_cyc),
    .i_wb_stb           (i_wb_stb),
    .i_wb_we            (i_wb_we),
    .i_wb_adr           (i_wb_adr),
    .i_wb_dat           (i_wb_dat),
    .o_wb_dat           (o_wb_dat),
    .o_wb_ack           (o_wb_ack),
    .i_link_phase       (link_phase),
    .i_sync_n           (i_sync_n),
    .o_link_enable      (link_enable),
    .o_char_replace     (char_replace),
    .o_octets_per_frame (octets_per_frame),
    .o_beats_per_mf     (beats_per_mf)
  );

  jesd_tx_lmfc lmfc_i (
    .clk                (clk),
    .reset              (reset),
    .i_sysref           (i_sysref),
    .i_octets_per_frame (octets_per_frame),
    .i_beats_per_mf     (beats_per_mf),
    .o_lmfc_edge        (o_lmfc_edge),
    .o_beat             (beat),
    .o_eof              (eof),
    .o_eomf             (eomf)
  );

  jesd_tx_ctrl ctrl_i (
    .clk           (clk),
    .reset         (reset),
    .i_link_enable (link_enable),
    .i_sync_n      (i_sync_n),
    .i_lmfc_edge   (o_lmfc_edge),
    .o_phase       (link_phase),
    .o_ilas_mframe (ilas_mframe),
    .o_tx_ready    (o_tx_ready)
  );

  // One lane per 32-bit slice of the user and PHY buses
  for (genvar i = 0; i < `JESD_NUM_LANES; i++) begin : gen_lane
    jesd_tx_lane #(
      .LANE_ID (i)
    ) lane_i (
      .clk                (clk),
      .reset              (reset),
      .i_phase            (link_phase),
      .i_ilas_mframe      (ilas_mframe),
      .i_beat             (beat),
      .i_eof              (eof),
      .i_eomf             (eomf),
      .i_octets_per_frame (octets_per_frame),
      .i_beats_per_mf     (beats_per_mf),
      .i_char_replace     (char_replace),
      .i_tx_data          (i_tx_data[LANE_BITS*i +: LANE_BITS]),
      .i_tx_valid         (i_tx_valid),
      .o_phy_data         (o_phy_data[LANE_BITS*i +: LANE_BITS]),
      .o_phy_charisk      (o_phy_charisk[NOCT*i +: NOCT])
    );
  end

endmodule

/* tb/jesd_tx_checker.sv */
`timescale 1ns/1ps

`include "jesd_tx_consts.svh"

module jesd_tx_checker (
  input logic                                             clk,
  input logic                                             reset,
  input logic                                             i_wb_cyc,
  input logic                                             i_wb_stb,
  input logic                                             i_wb_ack,
  input logic                                             i_sync_n,
  input logic                                             i_tx_ready,
  input jesd_link_pkg::link_phase_t                       i_link_phase,
  input logic [`JESD_NUM_LANES*`JESD_OCTETS_PER_BEAT-1:0] i_phy_charisk
);
  import jesd_link_pkg::*;

  // Ack only answers a live request
  ack_in_request: assert property (@(posedge clk) disable iff (reset)
    i_wb_ack |-> (i_wb_cyc && i_wb_stb))
    else $error("Wishbone ack seen without cyc and stb");

  ack_single: assert property (@(posedge clk) disable iff (reset)
    i_wb_ack |=> !i_wb_ack)
    else $error("Wishbone ack high on two cycles in a row");

  // A sync request leaves DATA on the next beat
  sync_drops_ready: assert property (@(posedge clk) disable iff (reset)
    !i_sync_n |=> (!i_tx_ready && i_link_phase == PHASE_CGS))
    else $error("tx_ready or phase not back to CGS after SYNC~ went low");

  // PHY output lags the phase by one beat
  cgs_all_control: assert property (@(posedge clk) disable iff (reset)
    (i_link_phase == PHASE_CGS) |=> (&i_phy_charisk))
    else $error("CGS octet sent without its control flag");

endmodule

/* tb/jesd_tx_tb.sv */
`timescale 1ns/1ps

`include "jesd_tx_consts.svh"

module jesd_tx_tb;
  import jesd_cfg_pkg::*;
  import jesd_link_pkg::*;

  localparam int NL            = `JESD_NUM_LANES;
  localparam int NOCT          = `JESD_OCTETS_PER_BEAT;
  localparam int WB_TIMEOUT    = 8;
  localparam int READY_TIMEOUT = 200;
  localparam int DATA_BEATS    = 64;
  // Bus accesses, ready waits, data bursts, CGS hold, then a margin
  localparam int TEST_CYCLES   = 4 + 31 * (WB_TIMEOUT + 3) + 7 * READY_TIMEOUT +
                                 5 * (DATA_BEATS + 12) + 2 * 9 + 40;
  localparam int MARGIN        = 500;

  logic                   clk;
  logic                   reset;
  logic                   wb_cyc;
  logic                   wb_stb;
  logic                   wb_we;
  logic [2:0]             wb_adr;
  wb_word_t               wb_dat_w;
  wb_word_t               wb_dat_r;
  logic                   wb_ack;
  logic                   sysref;
  logic                   sync_n;
  logic [8*NL*NOCT-1:0]   tx_data;
  logic                   tx_valid;
  logic                   tx_ready;
  logic [8*NL*NOCT-1:0]   phy_data;
  logic [NL*NOCT-1:0]     phy_charisk;
  logic                   lmfc_edge;

  // Reference model state, as held by the DUT after the last rising edge
  logic                   sr_q;
  logic                   sr_qq;
  int                     m_beat;
  link_phase_t            m_phase;
  int                     m_mf;
  logic [7:0]             m_prev [NL];
  logic                   m_ack;
  logic                   m_en;
  logic                   m_repl;
  int                     m_f;
  int                     m_k;
  logic [8*NL*NOCT-1:0]   exp_data;
  logic [NL*NOCT-1:0]     exp_k;

  int                     model_errs;
  int                     proc_errs;
  int                     errs_at_start;
  int                     passes;
  int                     fails;
  string                  test_name;

  jesd_tx jesd_tx_i (
    .clk           (clk),
    .reset         (reset),
    .i_wb_cyc      (wb_cyc),
    .i_wb_stb      (wb_stb),
    .i_wb_we       (wb_we),
    .i_wb_adr      (wb_adr),
    .i_wb_dat      (wb_dat_w),
    .o_wb_dat      (wb_dat_r),
    .o_wb_ack      (wb_ack),
    .i_sysref      (sysref),
    .i_sync_n      (sync_n),
    .i_tx_data     (tx_data),
    .i_tx_valid    (tx_valid),
    .o_tx_ready    (tx_ready),
    .o_phy_data    (phy_data),
    .o_phy_charisk (phy_charisk),
    .o_lmfc_edge   (lmfc_edge)
  );

  bind jesd_tx jesd_tx_checker protocol_check_i (
    .clk           (clk),
    .reset         (reset),
    .i_wb_cyc      (i_wb_cyc),
    .i_wb_stb      (i_wb_stb),
    .i_wb_ack      (o_wb_ack),
    .i_sync_n      (i_sync_n),
    .i_tx_ready    (o_tx_ready),
    .i_link_phase  (link_phase),
    .i_phy_charisk (o_phy_charisk)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    repeat (TEST_CYCLES + MARGIN) @(posedge clk);
    $display("Watchdog timeout, the tests did not finish within %0d cycles",
             TEST_CYCLES + MARGIN);
    $display("Regression failed");
    $finish;
  end

  // ************************************************************
  // Reference model, evaluated on the falling edge
  // ************************************************************

  always @(negedge clk) begin : model
    int         bpm;
    int         n;
    int         pos;
    int         mf_idx;
    logic [7:0] oct;
    logic [7:0] chain;
    logic       is_eof;
    if (reset) begin
      sr_q     = 1'b0;
      sr_qq    = 1'b0;
      m_beat   = 0;
      m_phase  = PHASE_CGS;
      m_mf     = 0;
      m_ack    = 1'b0;
      m_en     = 1'b0;
      m_repl   = 1'b1;
      m_f      = 2;
      m_k      = 16;
      m_prev   = '{default: 8'h00};
      exp_data = {NL*NOCT{`JESD_K_K}};
      exp_k    = '1;
    end else begin
      assert (phy_data == exp_data && phy_charisk == exp_k) else begin
        $display("[FAIL] %s phy expected %h/%h actual %h/%h", test_name,
                 exp_data, exp_k, phy_data, phy_charisk);
        model_errs++;
      end
      assert (tx_ready == (m_phase == PHASE_DATA)) else begin
        $display("[FAIL] %s tx_ready expected %0b actual %0b", test_name,
                 m_phase == PHASE_DATA, tx_ready);
        model_errs++;
      end
      assert (lmfc_edge == (m_beat == 0) && wb_ack == m_ack) else begin
        $display("[FAIL] %s lmfc_edge/ack expected %0b/%0b actual %0b/%0b", test_name,
                 m_beat == 0, m_ack, lmfc_edge, wb_ack);
        model_errs++;
      end
      bpm    = m_f * m_k / 4;
      mf_idx = (m_mf + ((m_beat == 0) ? 1 : 0)) % 4;
      for (int l = 0; l < NL; l++) begin
        chain = m_prev[l];
        for (int p = 0; p < NOCT; p++) begin
          n      = m_beat * NOCT + p;
          pos    = NOCT * l + p;
          is_eof = (m_f == 1) || (m_f == 2 && p % 2 == 1) || (p == NOCT - 1);
          oct    = tx_valid ? tx_data[8*pos +: 8] : 8'h00;
          exp_data[8*pos +: 8] = `JESD_K_K;
          exp_k[pos]           = 1'b1;
          if (m_phase == PHASE_ILAS) begin
            exp_data[8*pos +: 8] = 8'(n);
            exp_k[pos]           = (n == 0) || (n == bpm * NOCT - 1) ||
                                   (mf_idx == 1 && n == 1);
            if (n == 0) exp_data[8*pos +: 8] = `JESD_K_R;
            else if (n == bpm * NOCT - 1) exp_data[8*pos +: 8] = `JESD_K_A;
            else if (mf_idx == 1 && n == 1) exp_data[8*pos +: 8] = `JESD_K_Q;
            else if (mf_idx == 1 && n == 2) exp_data[8*pos +: 8] = 8'(l);
            else if (mf_idx == 1 && n == 3) exp_data[8*pos +: 8] = 8'(m_f - 1);
            else if (mf_idx == 1 && n == 4) exp_data[8*pos +: 8] = 8'(m_k - 1);
          end else if (m_phase == PHASE_DATA) begin
            exp_data[8*pos +: 8] = oct;
            exp_k[pos]           = m_repl && is_eof && oct == chain;
            if (exp_k[pos]) begin
              exp_data[8*pos +: 8] = (m_beat == bpm - 1 && p == NOCT - 1) ?
                                     `JESD_K_A : `JESD_K_F;
            end
            if (is_eof) chain = oct;
          end
        end
        m_prev[l] = (m_phase == PHASE_DATA) ? chain : 8'h00;
      end
      // Phase and multiframe counter for the next beat
      if (!(m_en && sync_n)) begin
        m_phase = PHASE_CGS;
        m_mf    = 0;
      end else if (m_beat == 0 && m_phase == PHASE_CGS) begin
        m_phase = PHASE_ILAS;
        m_mf    = 0;
      end else if (m_beat == 0 && m_phase == PHASE_ILAS) begin
        if (m_mf == `JESD_ILAS_MFRAMES - 1) m_phase = PHASE_DATA;
        else m_mf++;
      end
      if ((sr_q && !sr_qq) || m_beat >= bpm - 1) m_beat = 0;
      else m_beat++;
      sr_qq = sr_q;
      sr_q  = sysref;
      m_ack = wb_cyc && wb_stb && !m_ack;
      if (m_ack && wb_we) begin
        case (reg_addr_t'(wb_adr))
          REG_CTRL: begin
            m_en   = wb_dat_w[0];
            m_repl = wb_dat_w[1];
          end
          REG_FRAME:  m_f = int'(wb_dat_w[2:0]);
          REG_MFRAME: m_k = int'(wb_dat_w[5:0]);
          default: ;
        endcase
      end
    end
  end

  // ************************************************************
  // Stimulus tasks
  // ************************************************************

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic bus_access(input logic we, input reg_addr_t adr, input wb_word_t dat,
                            output wb_word_t rd);
    int waited;
    tick();
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = dat;
    waited   = 0;
    @(negedge clk);
    while (!wb_ack && waited < WB_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!wb_ack) begin
      $display("Wishbone access to register %0d was never acknowledged", adr);
      proc_errs++;
    end
    rd = wb_dat_r;
    tick();
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic write_reg(input reg_addr_t adr, input wb_word_t dat);
    wb_word_t rd_ignored;
    bus_access(1'b1, adr, dat, rd_ignored);
  endtask

  task automatic read_reg(input reg_addr_t adr, input wb_word_t expected);
    wb_word_t rd;
    bus_access(1'b0, adr, '0, rd);
    assert (rd == expected) else begin
      $display("[FAIL] %s register %0d expected %h actual %h", test_name, adr, expected, rd);
      proc_errs++;
    end
  endtask

  task automatic pulse_sysref();
    tick();
    sysref = 1'b1;
    repeat (2) tick();
    sysref = 1'b0;
  endtask

  task automatic wait_for_ready();
    int waited;
    waited = 0;
    @(negedge clk);
    while (!tx_ready && waited < READY_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!tx_ready) begin
      $display("%s: o_tx_ready did not rise within %0d cycles", test_name, READY_TIMEOUT);
      proc_errs++;
    end
  endtask

  // Link down, new F and K, realign to SYSREF, then let the receiver sync
  task automatic bring_up(input int f, input int k, input logic repl);
    tick();
    sync_n = 1'b0;
    write_reg(REG_CTRL, {30'd0, repl, 1'b0});
    write_reg(REG_FRAME, 32'(f));
    write_reg(REG_MFRAME, 32'(k));
    write_reg(REG_CTRL, {30'd0, repl, 1'b1});
    pulse_sysref();
    repeat (4) tick();
    sync_n = 1'b1;
    wait_for_ready();
  endtask

  // A frequent fixed octet makes equal end-of-frame octets likely
  task automatic send_data(input int beats);
    logic [8*NL*NOCT-1:0] word;
    for (int b = 0; b < beats; b++) begin
      for (int i = 0; i < NL * NOCT; i++) begin
        word[8*i +: 8] = ($urandom_range(0, 2) == 0) ? 8'h5A : 8'($urandom);
      end
      tick();
      tx_data  = word;
      tx_valid = ($urandom_range(0, 7) != 0);
    end
    tick();
    tx_valid = 1'b0;
    tx_data  = '0;
  endtask

  task automatic start_test(input string name);
    test_name     = name;
    errs_at_start = model_errs + proc_errs;
  endtask

  task automatic end_test();
    tick();
    if (model_errs + proc_errs == errs_at_start) begin
      passes++;
      $display("test %-12s ok", test_name);
    end else begin
      fails++;
      $display("test %-12s FAILED, %0d errors", test_name,
               model_errs + proc_errs - errs_at_start);
    end
  endtask

  // ************************************************************
  // Test sequence
  // ************************************************************

  initial begin
    void'($urandom(56849));
    reset    = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    sysref   = 1'b0;
    sync_n   = 1'b0;
    tx_data  = '0;
    tx_valid = 1'b0;
    test_name = "reset";
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;

    start_test("registers");
    read_reg(REG_ID, 32'h0000_204B);
    write_reg(REG_FRAME, 32'd4);
    write_reg(REG_MFRAME, 32'd8);
    write_reg(REG_CTRL, 32'd1);
    read_reg(REG_FRAME, 32'd4);
    read_reg(REG_MFRAME, 32'd8);
    read_reg(REG_CTRL, 32'd1);
    end_test();

    start_test("cgs");
    write_reg(REG_FRAME, 32'd2);
    write_reg(REG_MFRAME, 32'd16);
    write_reg(REG_CTRL, 32'd3);
    pulse_sysref();
    repeat (40) tick();
    end_test();

    start_test("ilas");
    sync_n = 1'b1;
    wait_for_ready();
    // DATA phase with SYNC~ high
    read_reg(REG_STATUS, 32'd6);
    end_test();

    for (int f = 1; f <= 4; f = f * 2) begin
      start_test($sformatf("data_f%0d", f));
      bring_up(f, 16, 1'b1);
      send_data(DATA_BEATS);
      end_test();
    end

    start_test("no_replace");
    bring_up(2, 16, 1'b0);
    send_data(DATA_BEATS);
    end_test();

    start_test("sync_loss");
    bring_up(2, 8, 1'b1);
    send_data(8);
    sync_n = 1'b0;
    @(negedge clk);
    @(negedge clk);
    assert (!tx_ready) else begin
      $display("[FAIL] %s tx_ready expected 0 actual %0b", test_name, tx_ready);
      proc_errs++;
    end
    @(negedge clk);
    assert (phy_charisk == '1) else begin
      $display("[FAIL] %s charisk expected %h actual %h", test_name, 8'hFF, phy_charisk);
      proc_errs++;
    end
    tick();
    sync_n = 1'b1;
    wait_for_ready();
    send_data(8);
    end_test();

    $display("%0d tests passed, %0d tests failed, %0d errors", passes, fails,
             model_errs + proc_errs);
    if (fails == 0 && model_errs + proc_errs == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+logic
logic/jesd_cfg_pkg.sv
logic/jesd_link_pkg.sv
logic/jesd_tx_regs.sv
logic/jesd_tx_lmfc.sv
logic/jesd_tx_ctrl.sv
logic/jesd_tx_lane.sv
logic/jesd_tx.sv
tb/jesd_tx_checker.sv
tb/jesd_tx_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= jesd_tx_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "Regression passed" $(LOG); then echo "FAIL, no result"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
